//--- logic/sysregs_pkg.sv
// register map of the system register window, imported by the decoder and the register blocks
`default_nettype none

package sysregs_pkg;

    localparam int REG_ADDR_W = 5;                  // 32 registers in the window
    localparam int DATA_W     = 8;                  // byte-wide cpu bus

    // window base sits at offset 0x10 of the raw address, xor moves it to 0
    localparam logic [REG_ADDR_W-1:0] WIN_XOR = 5'b10000;

    // rotated offsets of the implemented registers
    localparam logic [REG_ADDR_W-1:0] OFS_BLOCK_AB   = 5'h00;  // also zero page $00
    localparam logic [REG_ADDR_W-1:0] OFS_BLOCK_CF   = 5'h01;  // also zero page $01
    localparam logic [REG_ADDR_W-1:0] OFS_BLOCK_MASK = 5'h02;
    localparam logic [REG_ADDR_W-1:0] OFS_RMBCTRL    = 5'h03;
    localparam logic [REG_ADDR_W-1:0] OFS_SYSCTRL    = 5'h04;
    localparam logic [REG_ADDR_W-1:0] OFS_UART_CTRL  = 5'h05;
    localparam logic [REG_ADDR_W-1:0] OFS_UART_STAT  = 5'h06;
    localparam logic [REG_ADDR_W-1:0] OFS_UART_DATA  = 5'h07;  // rx/tx fifo port
    localparam logic [REG_ADDR_W-1:0] OFS_SPI_CTRL   = 5'h13;
    localparam logic [REG_ADDR_W-1:0] OFS_SPI_STAT   = 5'h14;
    localparam logic [REG_ADDR_W-1:0] OFS_SPI_DATA   = 5'h15;

    // decoded access target
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_BLOCK_AB,
        SEL_BLOCK_CF,
        SEL_BLOCK_MASK,
        SEL_RMBCTRL,
        SEL_SYSCTRL,
        SEL_UART_CTRL,
        SEL_UART_STAT,
        SEL_UART_DATA,
        SEL_SPI_CTRL,
        SEL_SPI_STAT,
        SEL_SPI_DATA
    } reg_sel_e;

    localparam logic [DATA_W-1:0] RST_BLOCK_MASK = 8'hFF;  // whole sram reachable
    localparam logic [DATA_W-1:0] RST_RMBCTRL    = 8'h80;  // boot rom mapped, cpu starts in it

    // sysctrl layout
    localparam logic [DATA_W-1:0] SYSCTRL_UNLOCK     = 8'h80;
    localparam logic [2:0]        SYSCTRL_ABRT02_BIT = 3'd6;
    localparam logic [2:0]        SYSCTRL_STOP_BIT   = 3'd1;
    localparam logic [2:0]        SYSCTRL_RESET_BIT  = 3'd0;

endpackage

`default_nettype wire

//--- logic/memmap_pkg.sv
// memory layout constants for the 8 kB block mapping, imported by the mapping registers and mapper
`default_nettype none

package memmap_pkg;

    localparam int BLOCK_W = 8;                     // 256 blocks of 8 kB in sram

    // rmbctrl bit positions
    localparam int RMB_BOOTROM   = 7;               // boot rom shown at $E000
    localparam int RMB_AUTOUNMAP = 6;               // drop boot rom after rti
    localparam int RMB_MIRROR    = 5;               // $9F50/51 mirrored at $00/$01
    localparam int RMB_ROM_CF    = 4;               // rom blocks at $C000-$FFFF
    localparam int RMB_RAM_CF    = 3;               // second ram window at $C000
    localparam int RMB_RDONLY_LO = 1;               // [2:1] write protect of cd and ef

    // ram blocks are numbered from the top half of sram
    localparam logic [BLOCK_W-1:0] BLOCK_FLIP = 8'h80;

    // rom area starts at sram block 64
    localparam logic [1:0] ROM_PREFIX = 2'b01;

    // fixed sram blocks when no window is enabled
    localparam logic [BLOCK_W-1:0] FIXED_CD_BLOCK = 8'd6;
    localparam logic [BLOCK_W-1:0] FIXED_EF_BLOCK = 8'd7;

    localparam int ROMBANK_W = 5;                   // 32 rom banks of 16 kB

endpackage

`default_nettype wire

//--- logic/sysregs_decode.sv
// address decoder of the register window, drives read data, register writes and peripheral strobes
`default_nettype none

module sysregs_decode
    import sysregs_pkg::*;
(
    input  wire logic                  clk,             // only samples the select check
    input  wire logic [REG_ADDR_W-1:0] addr_i,
    input  wire logic [DATA_W-1:0]     wdata_i,         // valid late in the cycle
    input  wire logic                  wvalid_i,
    input  wire logic                  req_i,           // window chip select
    input  wire logic                  req_bregs_i,     // zero page $00/$01 alias
    input  wire logic                  rwn_i,           // 1 = read
    output logic      [DATA_W-1:0]     rdata_o,
    // readback sources
    input  wire logic [DATA_W-1:0]     block_ab_i,
    input  wire logic [DATA_W-1:0]     block_cf_i,
    input  wire logic [DATA_W-1:0]     block_mask_i,
    input  wire logic [DATA_W-1:0]     rmbctrl_i,
    input  wire logic                  abrt02_en_i,
    input  wire logic [DATA_W-1:0]     usbuart_d_i,
    input  wire logic [DATA_W-1:0]     spireg_d_i,
    // internal register writes
    output logic                       wr_block_ab_o,
    output logic                       wr_block_cf_o,
    output logic                       wr_block_mask_o,
    output logic                       wr_rmbctrl_o,
    output logic                       wr_sysctrl_o,
    output logic      [DATA_W-1:0]     wdata_o,
    // usb uart core
    output logic      [DATA_W-1:0]     usbuart_d_o,
    output logic                       usbuart_wr_o,
    output logic                       usbuart_rd_o,
    output logic                       usbuart_cs_ctrl_o,
    output logic                       usbuart_cs_stat_o,
    output logic                       usbuart_cs_data_o,
    // spi flash master
    output logic      [DATA_W-1:0]     spireg_d_o,
    output logic                       spireg_wr_o,
    output logic                       spireg_rd_o,
    output logic                       spireg_cs_ctrl_o,
    output logic                       spireg_cs_stat_o,
    output logic                       spireg_cs_data_o
);

    logic [REG_ADDR_W-1:0] offset;                  // window-relative register number
    reg_sel_e              sel;
    logic                  wr_en;
    logic                  rd_en;
    logic                  uart_cs;
    logic                  spi_cs;

    assign offset = addr_i ^ WIN_XOR;
    assign wr_en  = !rwn_i && wvalid_i;
    assign rd_en  = rwn_i && wvalid_i;

    always_comb
    begin
        sel = SEL_NONE;
        if (req_bregs_i)
        begin
            // zero page alias only knows the two block registers
            sel = addr_i[0] ? SEL_BLOCK_CF : SEL_BLOCK_AB;
        end
        else if (req_i)
        begin
            case (offset)
                OFS_BLOCK_AB:   sel = SEL_BLOCK_AB;
                OFS_BLOCK_CF:   sel = SEL_BLOCK_CF;
                OFS_BLOCK_MASK: sel = SEL_BLOCK_MASK;
                OFS_RMBCTRL:    sel = SEL_RMBCTRL;
                OFS_SYSCTRL:    sel = SEL_SYSCTRL;
                OFS_UART_CTRL:  sel = SEL_UART_CTRL;
                OFS_UART_STAT:  sel = SEL_UART_STAT;
                OFS_UART_DATA:  sel = SEL_UART_DATA;
                OFS_SPI_CTRL:   sel = SEL_SPI_CTRL;
                OFS_SPI_STAT:   sel = SEL_SPI_STAT;
                OFS_SPI_DATA:   sel = SEL_SPI_DATA;
                default:        sel = SEL_NONE;     // ps2 and empty slots
            endcase
        end
    end

    // read mux, unselected offsets give 0
    always_comb
    begin
        rdata_o = '0;
        case (sel)
            SEL_BLOCK_AB:   rdata_o = block_ab_i;
            SEL_BLOCK_CF:   rdata_o = block_cf_i;
            SEL_BLOCK_MASK: rdata_o = block_mask_i;
            SEL_RMBCTRL:    rdata_o = rmbctrl_i;
            SEL_SYSCTRL:    rdata_o[SYSCTRL_ABRT02_BIT] = abrt02_en_i;  // pulse bits read 0
            SEL_UART_CTRL, SEL_UART_STAT, SEL_UART_DATA: rdata_o = usbuart_d_i;
            SEL_SPI_CTRL, SEL_SPI_STAT, SEL_SPI_DATA:    rdata_o = spireg_d_i;
            default:        rdata_o = '0;
        endcase
    end

    assign wr_block_ab_o   = (sel == SEL_BLOCK_AB) && wr_en;
    assign wr_block_cf_o   = (sel == SEL_BLOCK_CF) && wr_en;
    assign wr_block_mask_o = (sel == SEL_BLOCK_MASK) && wr_en;
    assign wr_rmbctrl_o    = (sel == SEL_RMBCTRL) && wr_en;
    assign wr_sysctrl_o    = (sel == SEL_SYSCTRL) && wr_en;
    assign wdata_o         = wdata_i;

    assign usbuart_cs_ctrl_o = (sel == SEL_UART_CTRL);
    assign usbuart_cs_stat_o = (sel == SEL_UART_STAT);
    assign usbuart_cs_data_o = (sel == SEL_UART_DATA);
    assign uart_cs           = usbuart_cs_ctrl_o || usbuart_cs_stat_o || usbuart_cs_data_o;
    assign usbuart_wr_o      = uart_cs && wr_en;
    assign usbuart_rd_o      = uart_cs && rd_en;   // rd pops the rx fifo
    assign usbuart_d_o       = wdata_i;

    assign spireg_cs_ctrl_o = (sel == SEL_SPI_CTRL);
    assign spireg_cs_stat_o = (sel == SEL_SPI_STAT);
    assign spireg_cs_data_o = (sel == SEL_SPI_DATA);
    assign spi_cs           = spireg_cs_ctrl_o || spireg_cs_stat_o || spireg_cs_data_o;
    assign spireg_wr_o      = spi_cs && wr_en;
    assign spireg_rd_o      = spi_cs && rd_en;
    assign spireg_d_o       = wdata_i;

    // window and zero page alias are distinct cpu addresses, the alias would hide a window access
    a_one_target: assert property (@(posedge clk)
        !(req_i && req_bregs_i));

endmodule

`default_nettype wire

//--- logic/memmap_regs.sv
// memory-mapping configuration registers with boot rom map and unmap from the cpu core
`default_nettype none

module memmap_regs
    import sysregs_pkg::*;
    import memmap_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire logic              wr_block_ab_i,
    input  wire logic              wr_block_cf_i,
    input  wire logic              wr_block_mask_i,
    input  wire logic              wr_rmbctrl_i,
    input  wire logic [DATA_W-1:0] wdata_i,
    input  wire logic              map_bootrom_i,       // isafix handler entry
    input  wire logic              unmap_bootrom_i,     // rti out of the handler
    output logic      [DATA_W-1:0] block_ab_o,
    output logic      [DATA_W-1:0] block_cf_o,          // ram block cd or rom bank
    output logic      [DATA_W-1:0] block_mask_o,
    output logic      [DATA_W-1:0] rmbctrl_o,
    output logic                   bootrom_in_block_ef_o,
    output logic                   auto_unmap_bootrom_o,
    output logic                   mirror_bregs_zp_o,
    output logic      [1:0]        rdonly_cdef_o        // [1] ef, [0] cd
);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            block_ab_o   <= '0;
            block_cf_o   <= '0;
            block_mask_o <= RST_BLOCK_MASK;
            rmbctrl_o    <= RST_RMBCTRL;
        end
        else
        begin
            if (wr_block_ab_i)
                block_ab_o <= wdata_i;
            if (wr_block_cf_i)
                block_cf_o <= wdata_i;
            if (wr_block_mask_i)
                block_mask_o <= wdata_i;

            // cpu core pulses beat a register write, unmap first
            if (unmap_bootrom_i)
            begin
                rmbctrl_o[RMB_BOOTROM]   <= 1'b0;
                rmbctrl_o[RMB_AUTOUNMAP] <= 1'b0;
            end
            else if (map_bootrom_i)
                rmbctrl_o[RMB_BOOTROM] <= 1'b1;    // other bits kept
            else if (wr_rmbctrl_i)
                rmbctrl_o <= wdata_i;
        end
    end

    // flags go straight to the bus controller
    assign bootrom_in_block_ef_o = rmbctrl_o[RMB_BOOTROM];
    assign auto_unmap_bootrom_o  = rmbctrl_o[RMB_AUTOUNMAP];
    assign mirror_bregs_zp_o     = rmbctrl_o[RMB_MIRROR];
    assign rdonly_cdef_o         = rmbctrl_o[RMB_RDONLY_LO +: 2];

    // the cpu core enters or leaves the handler, never both at once
    a_map_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(map_bootrom_i && unmap_bootrom_i));

endmodule

`default_nettype wire

//--- logic/block_mapper.sv
// registered translation of the mapping registers into sram block numbers for the bus controller
`default_nettype none

module block_mapper
    import memmap_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               resetn,
    input  wire logic [BLOCK_W-1:0] block_ab_i,
    input  wire logic [BLOCK_W-1:0] block_cf_i,
    input  wire logic [BLOCK_W-1:0] block_mask_i,
    input  wire logic [BLOCK_W-1:0] rmbctrl_i,
    output logic      [BLOCK_W-1:0] mm_block_ab_o,      // $A000-$BFFF
    output logic      [BLOCK_W-1:0] mm_block_cd_o,      // $C000-$DFFF
    output logic      [BLOCK_W-1:0] mm_block_ef_o,      // $E000-$FFFF when boot rom is off
    output logic      [BLOCK_W-1:0] mm_vp_block_ef_o    // same window for vector pulls
);

    logic [BLOCK_W-1:0]   ab_masked;
    logic [BLOCK_W-1:0]   cf_masked;
    logic [ROMBANK_W-1:0] rombank;

    assign ab_masked = block_ab_i & block_mask_i;
    assign cf_masked = block_cf_i & block_mask_i;
    assign rombank   = block_cf_i[ROMBANK_W-1:0];

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            // matches the reset register values
            mm_block_ab_o    <= BLOCK_FLIP;
            mm_block_cd_o    <= FIXED_CD_BLOCK;
            mm_block_ef_o    <= FIXED_EF_BLOCK;
            mm_vp_block_ef_o <= FIXED_EF_BLOCK;
        end
        else
        begin
            mm_block_ab_o <= ab_masked ^ BLOCK_FLIP;
            if (rmbctrl_i[RMB_ROM_CF])
            begin
                // 16 kB rom bank split over cd and ef
                mm_block_cd_o    <= {ROM_PREFIX, rombank, 1'b0};
                mm_block_ef_o    <= {ROM_PREFIX, rombank, 1'b1};
                mm_vp_block_ef_o <= {ROM_PREFIX, {ROMBANK_W{1'b0}}, 1'b1};  // vectors from bank 0
            end
            else
            begin
                mm_block_cd_o    <= rmbctrl_i[RMB_RAM_CF] ? (cf_masked ^ BLOCK_FLIP)
                                                          : FIXED_CD_BLOCK;
                mm_block_ef_o    <= FIXED_EF_BLOCK;
                mm_vp_block_ef_o <= FIXED_EF_BLOCK;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/sysctrl_reg.sv
// locked SYSCTRL register giving the abrt02 enable and one-cycle cpu stop and reset requests
`default_nettype none

module sysctrl_reg
    import sysregs_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire logic              cresn_i,             // cpu in reset when low
    input  wire logic              wr_sysctrl_i,
    input  wire logic [DATA_W-1:0] wdata_i,
    output logic                   abrt02_en_o,
    output logic                   cpu_stop_req_o,
    output logic                   cpu_reset_req_o
);

    logic unlocked_r;                               // set by writing the unlock byte

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            unlocked_r      <= 1'b0;
            abrt02_en_o     <= 1'b0;
            cpu_stop_req_o  <= 1'b0;
            cpu_reset_req_o <= 1'b0;
        end
        else
        begin
            cpu_stop_req_o  <= 1'b0;                // requests are single pulses
            cpu_reset_req_o <= 1'b0;

            if (wr_sysctrl_i)
            begin
                if (wdata_i == SYSCTRL_UNLOCK)
                    unlocked_r <= 1'b1;
                // bit 7 clear marks a real command
                if (unlocked_r && !wdata_i[DATA_W-1])
                begin
                    abrt02_en_o     <= wdata_i[SYSCTRL_ABRT02_BIT];
                    cpu_stop_req_o  <= wdata_i[SYSCTRL_STOP_BIT];
                    cpu_reset_req_o <= wdata_i[SYSCTRL_RESET_BIT];
                    unlocked_r      <= 1'b0;        // one command per unlock
                end
            end

            // cpu reset drops the abort handler and relocks
            if (!cresn_i)
            begin
                abrt02_en_o <= 1'b0;
                unlocked_r  <= 1'b0;
            end
        end
    end

    // the cpu core expects one-cycle requests
    a_stop_pulse: assert property (@(posedge clk) disable iff (!resetn)
        cpu_stop_req_o |=> !cpu_stop_req_o);
    a_reset_pulse: assert property (@(posedge clk) disable iff (!resetn)
        cpu_reset_req_o |=> !cpu_reset_req_o);

endmodule

`default_nettype wire

//--- logic/sysregs_top.sv
// system register block top level, connects the decoder, mapping registers, mapper and sysctrl
`default_nettype none

module sysregs_top (
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire logic       cresn_i,
    // cpu side register bus
    input  wire logic [4:0] addr_i,
    input  wire logic [7:0] wdata_i,
    input  wire logic       wvalid_i,
    input  wire logic       req_i,
    input  wire logic       req_bregs_i,
    input  wire logic       rwn_i,
    output logic      [7:0] rdata_o,
    // boot rom control from the cpu core
    input  wire logic       map_bootrom_i,
    input  wire logic       unmap_bootrom_i,
    // to the bus controller
    output logic      [7:0] mm_block_ab_o,
    output logic      [7:0] mm_block_cd_o,
    output logic      [7:0] mm_block_ef_o,
    output logic      [7:0] mm_vp_block_ef_o,
    output logic            bootrom_in_block_ef_o,
    output logic            mirror_bregs_zp_o,
    output logic            auto_unmap_bootrom_o,
    output logic      [1:0] rdonly_cdef_o,
    output logic            cpu_stop_req_o,
    output logic            cpu_reset_req_o,
    output logic            abrt02_en_o,
    // usb uart core
    input  wire logic [7:0] usbuart_d_i,
    output logic      [7:0] usbuart_d_o,
    output logic            usbuart_wr_o,
    output logic            usbuart_rd_o,
    output logic            usbuart_cs_ctrl_o,
    output logic            usbuart_cs_stat_o,
    output logic            usbuart_cs_data_o,
    // spi flash master
    input  wire logic [7:0] spireg_d_i,
    output logic      [7:0] spireg_d_o,
    output logic            spireg_wr_o,
    output logic            spireg_rd_o,
    output logic            spireg_cs_ctrl_o,
    output logic            spireg_cs_stat_o,
    output logic            spireg_cs_data_o
);

    logic [7:0] block_ab;
    logic [7:0] block_cf;
    logic [7:0] block_mask;
    logic [7:0] rmbctrl;
    logic [7:0] wdata;                              // register write data
    logic       wr_block_ab;
    logic       wr_block_cf;
    logic       wr_block_mask;
    logic       wr_rmbctrl;
    logic       wr_sysctrl;

    sysregs_decode u_decode (
        .clk               (clk),
        .addr_i            (addr_i),
        .wdata_i           (wdata_i),
        .wvalid_i          (wvalid_i),
        .req_i             (req_i),
        .req_bregs_i       (req_bregs_i),
        .rwn_i             (rwn_i),
        .rdata_o           (rdata_o),
        .block_ab_i        (block_ab),
        .block_cf_i        (block_cf),
        .block_mask_i      (block_mask),
        .rmbctrl_i         (rmbctrl),
        .abrt02_en_i       (abrt02_en_o),
        .usbuart_d_i       (usbuart_d_i),
        .spireg_d_i        (spireg_d_i),
        .wr_block_ab_o     (wr_block_ab),
        .wr_block_cf_o     (wr_block_cf),
        .wr_block_mask_o   (wr_block_mask),
        .wr_rmbctrl_o      (wr_rmbctrl),
        .wr_sysctrl_o      (wr_sysctrl),
        .wdata_o           (wdata),
        .usbuart_d_o       (usbuart_d_o),
        .usbuart_wr_o      (usbuart_wr_o),
        .usbuart_rd_o      (usbuart_rd_o),
        .usbuart_cs_ctrl_o (usbuart_cs_ctrl_o),
        .usbuart_cs_stat_o (usbuart_cs_stat_o),
        .usbuart_cs_data_o (usbuart_cs_data_o),
        .spireg_d_o        (spireg_d_o),
        .spireg_wr_o       (spireg_wr_o),
        .spireg_rd_o       (spireg_rd_o),
        .spireg_cs_ctrl_o  (spireg_cs_ctrl_o),
        .spireg_cs_stat_o  (spireg_cs_stat_o),
        .spireg_cs_data_o  (spireg_cs_data_o)
    );

    memmap_regs u_memmap_regs (
        .clk                   (clk),
        .resetn                (resetn),
        .wr_block_ab_i         (wr_block_ab),
        .wr_block_cf_i         (wr_block_cf),
        .wr_block_mask_i       (wr_block_mask),
        .wr_rmbctrl_i          (wr_rmbctrl),
        .wdata_i               (wdata),
        .map_bootrom_i         (map_bootrom_i),
        .unmap_bootrom_i       (unmap_bootrom_i),
        .block_ab_o            (block_ab),
        .block_cf_o            (block_cf),
        .block_mask_o          (block_mask),
        .rmbctrl_o             (rmbctrl),
        .bootrom_in_block_ef_o (bootrom_in_block_ef_o),
        .auto_unmap_bootrom_o  (auto_unmap_bootrom_o),
        .mirror_bregs_zp_o     (mirror_bregs_zp_o),
        .rdonly_cdef_o         (rdonly_cdef_o)
    );

    block_mapper u_block_mapper (
        .clk              (clk),
        .resetn           (resetn),
        .block_ab_i       (block_ab),
        .block_cf_i       (block_cf),
        .block_mask_i     (block_mask),
        .rmbctrl_i        (rmbctrl),
        .mm_block_ab_o    (mm_block_ab_o),
        .mm_block_cd_o    (mm_block_cd_o),
        .mm_block_ef_o    (mm_block_ef_o),
        .mm_vp_block_ef_o (mm_vp_block_ef_o)
    );

    sysctrl_reg u_sysctrl (
        .clk             (clk),
        .resetn          (resetn),
        .cresn_i         (cresn_i),
        .wr_sysctrl_i    (wr_sysctrl),
        .wdata_i         (wdata),
        .abrt02_en_o     (abrt02_en_o),
        .cpu_stop_req_o  (cpu_stop_req_o),
        .cpu_reset_req_o (cpu_reset_req_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_sysregs.sv
// trace-driven testbench for the system register block, built and run by the Makefile
`default_nettype none

module tb_sysregs;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int         CLK_PERIOD    = 20;
    localparam int         RESET_CYCLES  = 8;
    localparam int         MARGIN_CYCLES = 50;          // slack on top of the trace length
    localparam string      TRACE_FILE    = "bench/sysregs_trace.txt";
    localparam logic [7:0] UART_PATTERN  = 8'hA5;       // what the uart core returns
    localparam logic [7:0] SPI_PATTERN   = 8'h3C;

    // dut side, named as the ports
    logic       clk, resetn, cresn_i;
    logic [4:0] addr_i;
    logic [7:0] wdata_i, rdata_o;
    logic       wvalid_i, req_i, req_bregs_i, rwn_i;
    logic       map_bootrom_i, unmap_bootrom_i;
    logic [7:0] mm_block_ab_o, mm_block_cd_o, mm_block_ef_o, mm_vp_block_ef_o;
    logic       bootrom_in_block_ef_o, mirror_bregs_zp_o, auto_unmap_bootrom_o;
    logic [1:0] rdonly_cdef_o;
    logic       cpu_stop_req_o, cpu_reset_req_o, abrt02_en_o;
    logic [7:0] usbuart_d_i, usbuart_d_o;
    logic       usbuart_wr_o, usbuart_rd_o;
    logic       usbuart_cs_ctrl_o, usbuart_cs_stat_o, usbuart_cs_data_o;
    logic [7:0] spireg_d_i, spireg_d_o;
    logic       spireg_wr_o, spireg_rd_o;
    logic       spireg_cs_ctrl_o, spireg_cs_stat_o, spireg_cs_data_o;

    // one entry per trace line
    string       op_q[$];
    logic        bregs_q[$];
    logic [4:0]  addr_q[$];
    logic [7:0]  data_q[$], rdata_q[$];
    logic [7:0]  ab_q[$], cd_q[$], ef_q[$], vp_q[$];
    logic [5:0]  flags_q[$];
    logic [11:0] strobes_q[$];

    int   errors = 0;
    int   checks = 0;
    logic trace_loaded = 1'b0;

    sysregs_top u_sysregs_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_trace();
        int          fd;
        int          rc;
        int          n;
        string       line;
        string       op;
        logic        bregs;
        logic [4:0]  addr;
        logic [7:0]  data, rdata, ab, cd, ef, vp;
        logic [5:0]  flags;
        logic [11:0] strobes;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open the trace file %s", TRACE_FILE);
            return;
        end
        while (!$feof(fd))
        begin
            rc = $fgets(line, fd);
            if (rc > 1 && line.getc(0) != "#")      // skip blank and comment lines
            begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", op, bregs, addr, data,
                            rdata, ab, cd, ef, vp, flags, strobes);
                if (n == 11)
                begin
                    op_q.push_back(op);
                    bregs_q.push_back(bregs);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                    rdata_q.push_back(rdata);
                    ab_q.push_back(ab);
                    cd_q.push_back(cd);
                    ef_q.push_back(ef);
                    vp_q.push_back(vp);
                    flags_q.push_back(flags);
                    strobes_q.push_back(strobes);
                end
                else
                begin
                    errors++;
                    $display("trace line could not be parsed: %s", line);
                end
            end
        end
        $fclose(fd);
        if (op_q.size() == 0)
        begin
            errors++;
            $display("the trace file holds no entries");
        end
    endtask

    // bus access of one trace entry, map and unmap come with a write
    task automatic drive_line(input int idx);
        string op;
        op = op_q[idx];
        addr_i          <= addr_q[idx];
        wdata_i         <= data_q[idx];
        req_i           <= 1'b0;
        req_bregs_i     <= 1'b0;
        rwn_i           <= 1'b1;
        wvalid_i        <= 1'b0;
        map_bootrom_i   <= (op == "map");
        unmap_bootrom_i <= (op == "unmap");
        cresn_i         <= !(op == "cres");          // cpu held in reset for one cycle
        if (op == "write" || op == "read" || op == "map" || op == "unmap")
        begin
            req_i       <= !bregs_q[idx];
            req_bregs_i <= bregs_q[idx];            // zero page alias instead of window
            rwn_i       <= (op == "read");
            wvalid_i    <= 1'b1;
        end
        else if (op != "idle" && op != "cres")
        begin
            errors++;
            $display("unknown opcode %s in trace entry %0d", op, idx + 1);
        end
    endtask

    task automatic compare_field(input string what, input int idx,
                                 input logic [11:0] got, input logic [11:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Mismatch at %0t ns: trace entry %0d %s is %h, expected %h",
                     $time, idx + 1, what, got, expected);
        end
    endtask

    task automatic check_line(input int idx);
        logic [5:0]  flags;
        logic [11:0] strobes;
        flags   = {abrt02_en_o, bootrom_in_block_ef_o, auto_unmap_bootrom_o,
                   mirror_bregs_zp_o, rdonly_cdef_o};
        strobes = {usbuart_cs_ctrl_o, usbuart_cs_stat_o, usbuart_cs_data_o,
                   usbuart_wr_o, usbuart_rd_o,
                   spireg_cs_ctrl_o, spireg_cs_stat_o, spireg_cs_data_o,
                   spireg_wr_o, spireg_rd_o, cpu_stop_req_o, cpu_reset_req_o};
        if (op_q[idx] == "read")
            compare_field("rdata", idx, {4'd0, rdata_o}, {4'd0, rdata_q[idx]});
        compare_field("block ab", idx, {4'd0, mm_block_ab_o}, {4'd0, ab_q[idx]});
        compare_field("block cd", idx, {4'd0, mm_block_cd_o}, {4'd0, cd_q[idx]});
        compare_field("block ef", idx, {4'd0, mm_block_ef_o}, {4'd0, ef_q[idx]});
        compare_field("vp block ef", idx, {4'd0, mm_vp_block_ef_o}, {4'd0, vp_q[idx]});
        compare_field("flags", idx, {6'd0, flags}, {6'd0, flags_q[idx]});
        compare_field("strobes", idx, strobes, strobes_q[idx]);
        compare_field("uart wdata", idx, {4'd0, usbuart_d_o}, {4'd0, data_q[idx]});
        compare_field("spi wdata", idx, {4'd0, spireg_d_o}, {4'd0, data_q[idx]});
    endtask

    initial
    begin
        resetn          <= 1'b0;
        cresn_i         <= 1'b1;
        addr_i          <= '0;
        wdata_i         <= '0;
        wvalid_i        <= 1'b0;
        req_i           <= 1'b0;
        req_bregs_i     <= 1'b0;
        rwn_i           <= 1'b1;
        map_bootrom_i   <= 1'b0;
        unmap_bootrom_i <= 1'b0;
        usbuart_d_i     <= UART_PATTERN;            // fixed for the whole run
        spireg_d_i      <= SPI_PATTERN;
        load_trace();
        trace_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;                             // first entry goes out on this edge too
        for (int i = 0; i < op_q.size(); i++)
        begin
            drive_line(i);
            @(negedge clk);                         // everything settled mid cycle
            check_line(i);
            @(posedge clk);
        end
        $display("%0d trace entries, %0d checks, %0d errors", op_q.size(), checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // watchdog sized from the trace length
    initial
    begin
        int limit;
        wait (trace_loaded);
        limit = (RESET_CYCLES + op_q.size() + MARGIN_CYCLES) * CLK_PERIOD;
        #(limit);
        $display("timeout: the trace did not finish within %0d ns", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/sysregs_trace.txt
# op bregs addr data | expected: rdata ab cd ef vp flags{abrt02,bootrom,autounmap,mirror,rdonly}
# strobes{uart cs ctrl/stat/data,wr,rd, spi cs ctrl/stat/data,wr,rd, stop,reset}; map/unmap also write
read  0 13 00 80 80 06 07 07 10 000
read  0 12 00 FF 80 06 07 07 10 000
write 0 10 05 00 80 06 07 07 10 000
read  0 10 00 05 80 06 07 07 10 000
idle  0 00 00 00 85 06 07 07 10 000
write 0 11 2A 00 85 06 07 07 10 000
read  1 01 00 2A 85 06 07 07 10 000
read  1 00 00 05 85 06 07 07 10 000
write 1 00 1F 00 85 06 07 07 10 000
read  0 10 00 1F 85 06 07 07 10 000
write 0 12 0F 00 9F 06 07 07 10 000
read  0 12 00 0F 9F 06 07 07 10 000
write 0 13 88 00 8F 06 07 07 10 000
read  0 13 00 88 8F 06 07 07 10 000
idle  0 00 00 00 8F 8A 07 07 10 000
write 0 13 96 00 8F 8A 07 07 10 000
idle  0 00 00 00 8F 8A 07 07 13 000
idle  0 00 00 00 8F 54 55 41 13 000
write 0 12 FF 00 8F 54 55 41 13 000
write 0 13 28 00 8F 54 55 41 13 000
idle  0 00 00 00 9F 54 55 41 04 000
idle  0 00 00 00 9F AA 07 07 04 000
map   0 18 00 00 9F AA 07 07 04 000
read  0 13 00 A8 9F AA 07 07 14 000
write 0 13 48 00 9F AA 07 07 14 000
read  0 13 00 48 9F AA 07 07 08 000
map   0 13 00 00 9F AA 07 07 08 000
read  0 13 00 C8 9F AA 07 07 18 000
unmap 0 13 FF 00 9F AA 07 07 18 000
read  0 13 00 08 9F AA 07 07 00 000
write 0 13 00 00 9F AA 07 07 00 000
idle  0 00 00 00 9F AA 07 07 00 000
idle  0 00 00 00 9F 06 07 07 00 000
write 0 14 43 00 9F 06 07 07 00 000
read  0 14 00 00 9F 06 07 07 00 000
write 0 14 80 00 9F 06 07 07 00 000
write 0 14 43 00 9F 06 07 07 00 000
read  0 14 00 40 9F 06 07 07 20 003
idle  0 00 00 00 9F 06 07 07 20 000
write 0 14 00 00 9F 06 07 07 20 000
read  0 14 00 40 9F 06 07 07 20 000
write 0 14 80 00 9F 06 07 07 20 000
cres  0 00 00 00 9F 06 07 07 20 000
write 0 14 03 00 9F 06 07 07 00 000
read  0 14 00 00 9F 06 07 07 00 000
read  0 15 00 A5 9F 06 07 07 00 880
write 0 17 55 00 9F 06 07 07 00 300
read  0 16 00 A5 9F 06 07 07 00 480
read  0 03 00 3C 9F 06 07 07 00 044
write 0 04 11 00 9F 06 07 07 00 028
read  0 05 00 3C 9F 06 07 07 00 014
read  0 1E 00 00 9F 06 07 07 00 000
read  0 02 00 00 9F 06 07 07 00 000
read  0 18 00 00 9F 06 07 07 00 000
write 0 1A FF 00 9F 06 07 07 00 000
read  0 10 00 1F 9F 06 07 07 00 000
idle  0 00 00 00 9F 06 07 07 00 000

//--- sysregs_top.f
logic/sysregs_pkg.sv
logic/memmap_pkg.sv
logic/sysregs_decode.sv
logic/memmap_regs.sv
logic/block_mapper.sv
logic/sysctrl_reg.sv
logic/sysregs_top.sv
bench/tb_sysregs.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_sysregs
FILELIST  := sysregs_top.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))
PASS_MSG  := Testbench passed

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
